// File: compile.f
+incdir+.
riscv_core_mul_pkg.sv
riscv_core_mul_in.sv
riscv_core_mul_array.sv
riscv_core_mul_out.sv
riscv_core_mul.sv
tb_riscv_core_mul.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the multiply unit testbench with Verilator, result goes to sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_riscv_core_mul -o tb_sim > sim.log 2>&1 \
  && ./obj_dir/tb_sim >> sim.log 2>&1 \
  || echo "build or simulation returned an error status" >> sim.log
if grep -q "Test failed" sim.log || ! grep -q "Test completed successfully" sim.log
then
  echo "simulation FAILED, see sim.log"
  exit 1
fi
echo "simulation passed"

// File: tb_riscv_core_mul.sv
`default_nettype none

`include "riscv_core_mul_macros.svh"

module tb_riscv_core_mul;

  timeunit 1ns;
  timeprecision 100ps;

  import riscv_core_mul_pkg::*;

  localparam int XLEN         = `RISCV_MUL_XLEN;
  localparam int HALF         = XLEN / 2;
  localparam int STAGES       = `RISCV_MUL_STAGES;
  localparam int RESET_CYCLES = 10;
  localparam int N_IDLE       = 20;
  localparam int N_DIRECTED   = 32;                // upper bound on the hand-picked cases
  localparam int N_SIGNED     = 200;
  localparam int N_MIXED      = 200;
  localparam int N_WORD       = 150;
  localparam int N_TRAFFIC    = 400;
  localparam int TOTAL_CYCLES = RESET_CYCLES + N_IDLE + N_DIRECTED + N_SIGNED + N_MIXED
                                + N_WORD + N_TRAFFIC + STAGES + 1;
  localparam int WATCHDOG_NS  = TOTAL_CYCLES * 8 + 200;

  localparam logic [XLEN-1:0] ZERO          = '0;
  localparam logic [XLEN-1:0] ONE           = {{(XLEN-1){1'b0}}, 1'b1};
  localparam logic [XLEN-1:0] ALL_ONES      = '1;
  localparam logic [XLEN-1:0] MOST_NEG      = {1'b1, {(XLEN-1){1'b0}}};
  localparam logic [XLEN-1:0] MOST_NEG_WORD = {{(HALF+1){1'b1}}, {(HALF-1){1'b0}}};

  logic     clk;
  logic     arst_n;
  logic     valid;
  mul_req_t req;
  mul_rsp_t rsp;

  integer   seed;
  int       num_checks;
  mul_rsp_t exp_q[$];                              // one expected response per clock cycle
  string    name_q[$];                             // test name that goes with each entry

  always #4 clk = ~clk;

  riscv_core_mul i_riscv_core_mul (
    .i_clk    (clk),
    .i_arst_n (arst_n),
    .i_valid  (valid),
    .i_req    (req),
    .o_rsp    (rsp)
  );

  function automatic int unsigned pick(input int unsigned n);
    int unsigned r;
    r = $unsigned($random(seed));
    return r % n;
  endfunction

  function automatic logic [XLEN-1:0] rand_value();
    logic [XLEN-1:0] v;
    logic [31:0]     r;
    v = '0;
    r = '0;
    for (int i = 0; i < XLEN; i++)
    begin
      if (i % 32 == 0)
      begin
        r = $random(seed);
      end
      v[i] = r[i % 32];
    end
    return v;
  endfunction

  // corner values come up about a third of the time
  function automatic logic [XLEN-1:0] pick_operand();
    case (pick(16))
      0:       return ZERO;
      1:       return ONE;
      2:       return ALL_ONES;
      3:       return MOST_NEG;
      4:       return MOST_NEG_WORD;
      default: return rand_value();
    endcase
  endfunction

  function automatic mul_req_t make_req(input mul_op_e op, input logic is_word,
                                        input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    mul_req_t r;
    r.op     = op;
    r.isword = is_word;
    r.src_a  = a;
    r.src_b  = b;
    return r;
  endfunction

  function automatic logic [XLEN-1:0] sext_word(input logic [XLEN-1:0] v);
    return {{HALF{v[HALF-1]}}, v[HALF-1:0]};
  endfunction

  // full-width product of the operands as the ISA reads them, then the wanted half
  function automatic mul_rsp_t model_rsp(input logic v, input mul_req_t r);
    logic [XLEN-1:0]          a;
    logic [XLEN-1:0]          b;
    logic signed [2*XLEN-1:0] wide_a;
    logic signed [2*XLEN-1:0] wide_b;
    logic signed [2*XLEN-1:0] prod;
    mul_rsp_t                 m;
    m = '0;
    if (!v)
    begin
      return m;                                    // idle cycles expect an all-zero response
    end
    a = r.isword ? sext_word(r.src_a) : r.src_a;
    b = r.isword ? sext_word(r.src_b) : r.src_b;
    wide_a = (r.op == MUL_HI_UU) ? {{XLEN{1'b0}}, a} : {{XLEN{a[XLEN-1]}}, a};
    if (r.op == MUL_LO || r.op == MUL_HI_SS)
    begin
      wide_b = {{XLEN{b[XLEN-1]}}, b};
    end
    else
    begin
      wide_b = {{XLEN{1'b0}}, b};                  // rs2 of MULHSU and MULHU is unsigned
    end
    prod    = wide_a * wide_b;
    m.valid = 1'b1;
    if (r.isword)
    begin
      m.result = {{HALF{prod[HALF-1]}}, prod[HALF-1:0]};
    end
    else if (r.op == MUL_LO)
    begin
      m.result = prod[XLEN-1:0];
    end
    else
    begin
      m.result = prod[2*XLEN-1:XLEN];
    end
    return m;
  endfunction

  task automatic check_rsp(input string name, input mul_rsp_t exp, input mul_rsp_t act);
    num_checks++;
    if (act !== exp)
    begin
      $display("ERROR [%s] expected valid=%0b result=0x%h, actual valid=%0b result=0x%h",
               name, exp.valid, exp.result, act.valid, act.result);
      $display("Test failed");
      $fatal(1, "response mismatch in %s", name);
    end
  endtask

  // drive one cycle and check the response that is due at the falling edge
  task automatic issue(input string name, input logic v, input mul_req_t r);
    mul_rsp_t exp;
    string    exp_name;
    @(posedge clk);
    #1;
    valid = v;
    req   = r;
    exp_q.push_back(model_rsp(v, r));
    name_q.push_back(name);
    @(negedge clk);
    if (exp_q.size() > STAGES)
    begin
      exp      = exp_q.pop_front();
      exp_name = name_q.pop_front();
      check_rsp(exp_name, exp, rsp);
    end
  endtask

  initial
  begin : main_proc
    mul_op_e         op;
    logic            is_word;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] junk;
    clk        = 1'b0;
    arst_n     = 1'b0;
    valid      = 1'b0;
    req        = '0;
    seed       = 32'h58aa;
    num_checks = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    for (int i = 0; i < STAGES; i++)
    begin
      exp_q.push_back('0);                         // the pipeline still holds reset values
      name_q.push_back("idle_after_reset");
    end

    for (int i = 0; i < N_IDLE; i++)
    begin
      issue("idle_after_reset", 1'b0, make_req(MUL_HI_UU, 1'b0, rand_value(), rand_value()));
    end

    for (int k = 0; k < 2; k++)
    begin
      op = (k == 0) ? MUL_LO : MUL_HI_SS;
      issue("signed_corner", 1'b1, make_req(op, 1'b0, MOST_NEG, MOST_NEG));
      issue("signed_corner", 1'b1, make_req(op, 1'b0, MOST_NEG, ALL_ONES));
      issue("signed_corner", 1'b1, make_req(op, 1'b0, ALL_ONES, ALL_ONES));
      issue("signed_corner", 1'b1, make_req(op, 1'b0, ONE, MOST_NEG));
      issue("signed_corner", 1'b1, make_req(op, 1'b0, ZERO, ALL_ONES));
    end
    for (int i = 0; i < N_SIGNED; i++)
    begin
      op = (pick(2) == 0) ? MUL_LO : MUL_HI_SS;
      issue("signed_random", 1'b1, make_req(op, 1'b0, pick_operand(), pick_operand()));
    end

    for (int k = 0; k < 2; k++)
    begin
      op = (k == 0) ? MUL_HI_SU : MUL_HI_UU;
      issue("mixed_corner", 1'b1, make_req(op, 1'b0, MOST_NEG, ALL_ONES));
      issue("mixed_corner", 1'b1, make_req(op, 1'b0, ALL_ONES, ALL_ONES));
      issue("mixed_corner", 1'b1, make_req(op, 1'b0, MOST_NEG, MOST_NEG));
      issue("mixed_corner", 1'b1, make_req(op, 1'b0, ALL_ONES, ONE));
      issue("mixed_corner", 1'b1, make_req(op, 1'b0, ONE, MOST_NEG));
    end
    for (int i = 0; i < N_MIXED; i++)
    begin
      op = (pick(2) == 0) ? MUL_HI_SU : MUL_HI_UU;
      issue("mixed_random", 1'b1, make_req(op, 1'b0, pick_operand(), pick_operand()));
    end

    // upper operand halves carry junk that a word multiply must not see
    issue("word_corner", 1'b1, make_req(MUL_LO, 1'b1, MOST_NEG_WORD, MOST_NEG_WORD));
    issue("word_corner", 1'b1, make_req(MUL_LO, 1'b1, MOST_NEG_WORD, ALL_ONES));
    issue("word_corner", 1'b1, make_req(MUL_LO, 1'b1, {HALF{2'b01}}, MOST_NEG));
    issue("word_corner", 1'b1, make_req(MUL_LO, 1'b1, ~MOST_NEG_WORD, ~MOST_NEG_WORD));
    for (int i = 0; i < N_WORD; i++)
    begin
      junk = rand_value();
      a    = pick_operand();
      a    = {junk[XLEN-1:HALF], a[HALF-1:0]};
      junk = rand_value();
      b    = pick_operand();
      b    = {junk[HALF-1:0], b[HALF-1:0]};
      issue("word_random", 1'b1, make_req(MUL_LO, 1'b1, a, b));
    end

    // mixed traffic where about one cycle in four is idle
    for (int i = 0; i < N_TRAFFIC; i++)
    begin
      op      = mul_op_e'(pick(4));
      is_word = (op == MUL_LO) && (pick(2) == 0);
      issue("interleaved_traffic", pick(4) != 0,
            make_req(op, is_word, pick_operand(), pick_operand()));
    end

    repeat (STAGES + 1)
    begin
      issue("drain", 1'b0, make_req(MUL_LO, 1'b0, ZERO, ZERO));
    end

    if (num_checks > 0)
    begin
      $display("Test completed successfully");
      $finish;
    end
    else
    begin
      $display("no response was compared during the run");
      $display("Test failed");
      $fatal(1, "empty run");
    end
  end

  initial
  begin : watchdog_proc
    #(WATCHDOG_NS);
    $display("simulation hung, the watchdog expired after %0d ns", WATCHDOG_NS);
    $display("Test failed");
    $fatal(1, "watchdog timeout");
  end

endmodule

`default_nettype wire

// File: riscv_core_mul.sv
`default_nettype none

`include "riscv_core_mul_macros.svh"

module riscv_core_mul
(
  input  wire                               i_clk,
  input  wire                               i_arst_n,
  input  wire logic                         i_valid,
  input  wire riscv_core_mul_pkg::mul_req_t i_req,
  output riscv_core_mul_pkg::mul_rsp_t      o_rsp
);

  import riscv_core_mul_pkg::*;

  localparam int XLEN   = `RISCV_MUL_XLEN;
  localparam int STAGES = `RISCV_MUL_STAGES;

  logic [XLEN-1:0]   mag_a;                      // unsigned rs1 magnitude
  logic [XLEN-1:0]   mag_b;                      // unsigned rs2 magnitude
  logic              arr_valid;                  // strobe at the end of the array
  mul_req_t          arr_req;                    // request delayed alongside the product
  logic [2*XLEN-1:0] product;
  logic [XLEN-1:0]   result;

  riscv_core_mul_in #(
    .XLEN (XLEN)
  ) i_riscv_core_mul_in (
    .i_req   (i_req),
    .o_mag_a (mag_a),
    .o_mag_b (mag_b)
  );

  riscv_core_mul_array #(
    .XLEN   (XLEN),
    .STAGES (STAGES)
  ) i_riscv_core_mul_array (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_valid   (i_valid),
    .i_req     (i_req),
    .i_mag_a   (mag_a),
    .i_mag_b   (mag_b),
    .o_valid   (arr_valid),
    .o_req     (arr_req),
    .o_product (product)
  );

  riscv_core_mul_out #(
    .XLEN (XLEN)
  ) i_riscv_core_mul_out (
    .i_mul_out_srcA    (arr_req.src_a),
    .i_mul_out_srcB    (arr_req.src_b),
    .i_mul_out_control (arr_req.op),
    .i_mul_out_isword  (arr_req.isword),
    .i_mul_out_en      (arr_valid),
    .i_mul_out_product (product),
    .o_mul_out_result  (result)
  );

  assign o_rsp = '{valid: arr_valid, result: result};

endmodule

`default_nettype wire

// File: riscv_core_mul_out.sv
`default_nettype none

`include "riscv_core_mul_macros.svh"

module riscv_core_mul_out
#(
  parameter int XLEN = `RISCV_MUL_XLEN
)
(
  input  wire logic [XLEN-1:0]             i_mul_out_srcA,
  input  wire logic [XLEN-1:0]             i_mul_out_srcB,
  input  wire riscv_core_mul_pkg::mul_op_e i_mul_out_control,
  input  wire logic                        i_mul_out_isword,
  input  wire logic                        i_mul_out_en,
  input  wire logic [2*XLEN-1:0]           i_mul_out_product,
  output logic [XLEN-1:0]                  o_mul_out_result
);

  import riscv_core_mul_pkg::*;

  localparam int HALF = XLEN / 2;

  logic [2*XLEN-1:0] neg_product;                // two's complement of the magnitude product
  logic [2*XLEN-1:0] fixed_product;              // product with its sign restored
  logic              sign_a;                     // rs1 sign at the width of the operation
  logic              sign_b;                     // rs2 sign at the width of the operation
  logic              negate;
  logic [XLEN-1:0]   result;

  assign neg_product = ~i_mul_out_product + 1'b1;

  // word operations take their signs from the top bit of the low half
  assign sign_a = i_mul_out_isword ? i_mul_out_srcA[HALF-1] : i_mul_out_srcA[XLEN-1];
  assign sign_b = i_mul_out_isword ? i_mul_out_srcB[HALF-1] : i_mul_out_srcB[XLEN-1];

  always_comb
  begin : negate_proc
    case (i_mul_out_control)
      MUL_LO, MUL_HI_SS:
      begin
        negate = sign_a ^ sign_b;
      end
      MUL_HI_SU:
      begin
        negate = sign_a;                         // rs2 is unsigned so only rs1 can flip it
      end
      MUL_HI_UU:
      begin
        negate = 1'b0;
      end
      default:
      begin
        negate = 1'b0;
      end
    endcase
  end

  assign fixed_product = negate ? neg_product : i_mul_out_product;

  always_comb
  begin : select_proc
    if (i_mul_out_isword)
    begin
      result = {{HALF{fixed_product[HALF-1]}}, fixed_product[HALF-1:0]};  // MULW
    end
    else if (i_mul_out_control == MUL_LO)
    begin
      result = fixed_product[XLEN-1:0];
    end
    else
    begin
      result = fixed_product[2*XLEN-1:XLEN];     // every MULH variant wants the upper half
    end
  end

  // an idle cycle must present zero on the result bus
  assign o_mul_out_result = i_mul_out_en ? result : '0;

endmodule

`default_nettype wire

// File: riscv_core_mul_array.sv
`default_nettype none

`include "riscv_core_mul_macros.svh"

module riscv_core_mul_array
#(
  parameter int XLEN   = `RISCV_MUL_XLEN,
  parameter int STAGES = `RISCV_MUL_STAGES
)
(
  input  wire                               i_clk,
  input  wire                               i_arst_n,
  input  wire logic                         i_valid,
  input  wire riscv_core_mul_pkg::mul_req_t i_req,
  input  wire logic [XLEN-1:0]              i_mag_a,
  input  wire logic [XLEN-1:0]              i_mag_b,
  output logic                              o_valid,
  output riscv_core_mul_pkg::mul_req_t      o_req,
  output logic [2*XLEN-1:0]                 o_product
);

  import riscv_core_mul_pkg::*;

  localparam int ROWS = (XLEN + STAGES - 1) / STAGES;  // multiplier bits consumed per stage

  for (genvar s = 0; s < STAGES; s++)
  begin : g_stage
    logic [2*XLEN-1:0] sum_in;                   // running sum from the stage before
    logic [2*XLEN-1:0] sum_nxt;                  // running sum with this stage's rows added
    logic [2*XLEN-1:0] a_ext;                    // multiplicand widened to product width
    logic [XLEN-1:0]   a_in;
    logic [XLEN-1:0]   b_in;                     // multiplier bits not yet consumed, lsb first
    logic              valid_in;
    mul_req_t          req_in;
    logic [2*XLEN-1:0] sum_q;
    logic              valid_q;
    mul_req_t          req_q;

    if (s == 0)
    begin : g_first
      assign sum_in   = '0;
      assign a_in     = i_mag_a;
      assign b_in     = i_mag_b;
      assign valid_in = i_valid;
      assign req_in   = i_req;
    end
    else
    begin : g_next
      assign sum_in   = g_stage[s-1].sum_q;
      assign a_in     = g_stage[s-1].g_fwd.a_q;
      assign b_in     = g_stage[s-1].g_fwd.b_q;
      assign valid_in = g_stage[s-1].valid_q;
      assign req_in   = g_stage[s-1].req_q;
    end

    assign a_ext = {{XLEN{1'b0}}, a_in};

    // row r stands for multiplier bit s*ROWS+r, bits past XLEN are already zero
    always_comb
    begin : rows_proc
      sum_nxt = sum_in;
      for (int r = 0; r < ROWS; r++)
      begin
        if (b_in[r])
        begin
          sum_nxt = sum_nxt + (a_ext << (s * ROWS + r));
        end
      end
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin : valid_reg
      if (!i_arst_n)
      begin
        valid_q <= 1'b0;
      end
      else
      begin
        valid_q <= valid_in;
      end
    end

    always_ff @(posedge i_clk)
    begin : data_reg
      sum_q <= sum_nxt;
      req_q <= req_in;                           // the output stage needs the raw operand signs
    end

    // operands only travel on while a later stage still needs them
    if (s < STAGES - 1)
    begin : g_fwd
      logic [XLEN-1:0] a_q;
      logic [XLEN-1:0] b_q;

      always_ff @(posedge i_clk)
      begin : operand_reg
        a_q <= a_in;
        b_q <= b_in >> ROWS;                     // drop the bits this stage has used
      end
    end
  end

  assign o_valid   = g_stage[STAGES-1].valid_q;
  assign o_req     = g_stage[STAGES-1].req_q;
  assign o_product = g_stage[STAGES-1].sum_q;

  // a strobe leaves exactly STAGES cycles after it was sampled, with no loss or duplication
  a_valid_latency : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    $past(i_arst_n, STAGES) |-> (o_valid == $past(i_valid, STAGES))
  ) else $error("valid strobe not delayed by %0d cycles", STAGES);

endmodule

`default_nettype wire

// File: riscv_core_mul_in.sv
`default_nettype none

`include "riscv_core_mul_macros.svh"

module riscv_core_mul_in
#(
  parameter int XLEN = `RISCV_MUL_XLEN
)
(
  input  wire riscv_core_mul_pkg::mul_req_t i_req,
  output logic [XLEN-1:0]                   o_mag_a,
  output logic [XLEN-1:0]                   o_mag_b
);

  import riscv_core_mul_pkg::*;

  localparam int HALF = XLEN / 2;                // width of a word operand

  logic signed_a;                                // rs1 is read as a two's-complement value
  logic signed_b;                                // rs2 is read as a two's-complement value

  // word mode first widens the low half, then a negative signed value is flipped
  function automatic logic [XLEN-1:0] magnitude
  (
    input logic [XLEN-1:0] value,
    input logic            is_signed,
    input logic            is_word
  );
    logic [XLEN-1:0] ext;
    ext = is_word ? {{HALF{value[HALF-1]}}, value[HALF-1:0]} : value;
    if (is_signed && ext[XLEN-1])
    begin
      return ~ext + 1'b1;                        // the most negative value maps to 2^(XLEN-1)
    end
    return ext;
  endfunction

  always_comb
  begin : sign_sel_proc
    case (i_req.op)
      MUL_LO, MUL_HI_SS:
      begin
        signed_a = 1'b1;
        signed_b = 1'b1;
      end
      MUL_HI_SU:
      begin
        signed_a = 1'b1;
        signed_b = 1'b0;                         // rs2 of MULHSU is unsigned
      end
      MUL_HI_UU:
      begin
        signed_a = 1'b0;
        signed_b = 1'b0;
      end
      default:
      begin
        signed_a = 1'b0;
        signed_b = 1'b0;
      end
    endcase
  end

  assign o_mag_a = magnitude(i_req.src_a, signed_a, i_req.isword);
  assign o_mag_b = magnitude(i_req.src_b, signed_b, i_req.isword);

  // the output stage only knows how to finish a word result for MUL_LO
  always_comb
  begin : word_op_check
    a_word_is_mul_lo : assert (!i_req.isword || (i_req.op == MUL_LO))
      else $error("word mode requested with op %s", i_req.op.name());
  end

endmodule

`default_nettype wire

// File: riscv_core_mul_pkg.sv
`default_nettype none

`include "riscv_core_mul_macros.svh"

package riscv_core_mul_pkg;

  // the encoding follows the M extension funct3 order of the multiply group
  typedef enum logic [1:0]
  {
    MUL_LO    = 2'b00,                   // lower half, signed x signed (MUL, MULW)
    MUL_HI_SS = 2'b01,                   // upper half, signed x signed (MULH)
    MUL_HI_SU = 2'b10,                   // upper half, signed x unsigned (MULHSU)
    MUL_HI_UU = 2'b11                    // upper half, unsigned x unsigned (MULHU)
  } mul_op_e;

  // MULW is MUL_LO with isword set, any other op with isword is illegal
  typedef struct packed
  {
    mul_op_e                    op;      // which product half and which operands are signed
    logic                       isword;  // 32-bit word operation on the low operand halves
    logic [`RISCV_MUL_XLEN-1:0] src_a;   // rs1 value as read from the register file
    logic [`RISCV_MUL_XLEN-1:0] src_b;   // rs2 value as read from the register file
  } mul_req_t;

  typedef struct packed
  {
    logic                       valid;   // result is present in this cycle only
    logic [`RISCV_MUL_XLEN-1:0] result;  // zero whenever valid is low
  } mul_rsp_t;

endpackage

`default_nettype wire

// File: riscv_core_mul_macros.svh
`ifndef RISCV_CORE_MUL_MACROS_SVH
`define RISCV_CORE_MUL_MACROS_SVH

// operand width of the core
// it must be even because word mode works on the low half
`define RISCV_MUL_XLEN 64

// register stages in the array multiplier, between 1 and the operand width
// each stage adds ceil(XLEN / STAGES) partial-product rows, the last one may be short
`define RISCV_MUL_STAGES 3

`endif
